// File: hist.f
hdl/hist_pkg.sv
hdl/byte_credit_fifo.sv
hdl/bin_ram.sv
hdl/histogram_ctrl.sv
hdl/hist_top.sv
verification/hist_assert.sv
verification/hist_tb.sv

// File: run_hist.sh
#!/usr/bin/env bash
# build and run the histogram testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module hist_tb -f hist.f -Mdir obj_dir -o hist_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/hist_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi
exit 0

// File: verification/hist_tb.sv
`timescale 1ns/100ps

module hist_tb;

    localparam int PER_BYTE = 2 * (hist_pkg::SRAM_LAT + 1) + 1;
    localparam int CLEAR_CYC = hist_pkg::NUM_BINS * (hist_pkg::SRAM_LAT + 1);
    localparam int RAND_BYTES = 200;
    localparam int BURST_BYTES = 80;
    localparam int RESTART_BYTES = 40;
    // short stream and three longer ones plus an eof each
    localparam int ALL_BYTES = 5 + RAND_BYTES + BURST_BYTES + RESTART_BYTES + 3;
    // four clears plus three full bin sweeps and burst gaps of up to 9 cycles
    localparam int TIMEOUT_CYCLES = ALL_BYTES * PER_BYTE + 4 * CLEAR_CYC
        + 3 * 2 * hist_pkg::NUM_BINS + 10 * BURST_BYTES + 1000;

    logic                        clk;
    logic                        rst;
    logic                        start;
    hist_pkg::byte_msg_t         byte_in;
    logic                        credit;
    logic                        busy;
    logic                        done;
    logic [hist_pkg::BIN_W-1:0]  total;
    logic [hist_pkg::ADDR_W-1:0] rd_addr;
    logic [hist_pkg::BIN_W-1:0]  rd_data;

    // expected histogram built from the bytes actually sent
    logic [hist_pkg::BIN_W-1:0] model [hist_pkg::NUM_BINS];
    logic [hist_pkg::BIN_W-1:0] model_total;
    // sender side credit counter
    int credits;
    int errors;
    int cycle_count;
    logic [31:0] rng;

    hist_top DUT (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .byte_in (byte_in),
        .credit  (credit),
        .busy    (busy),
        .done    (done),
        .total   (total),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("sim failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // eof kept for the end of the stream
    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        rng = xorshift32(rng);
        b = rng[7:0];
        if (b == hist_pkg::EOF_CHAR) begin
            b = 8'h1b;
        end
        return b;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            errors++;
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // one clock
    // inputs change on the falling edge where credit is also sampled
    task automatic step();
        @(negedge clk);
        start = 1'b0;
        byte_in = '0;
        if (credit) begin
            credits++;
        end
        assert (credits <= hist_pkg::FIFO_DEPTH) else begin
            errors++;
            $display("at %0t the sender got back more credits than the buffer holds", $time);
        end
    endtask

    // waits for a credit and then drives the byte for one cycle
    task automatic send_byte(input logic [7:0] b);
        step();
        while (credits == 0) begin
            step();
        end
        byte_in.valid = 1'b1;
        byte_in.data = b;
        credits--;
        model[b] = model[b] + 1;
        model_total = model_total + 1;
    endtask

    task automatic start_run();
        step();
        start = 1'b1;
        for (int i = 0; i < hist_pkg::NUM_BINS; i++) begin
            model[i] = '0;
        end
        model_total = '0;
        // done drops as the clear begins
        step();
        check_value("done", 32'(done), 32'd0);
    endtask

    task automatic wait_done();
        while (!done) begin
            step();
        end
        check_value("total", total, model_total);
        // every popped byte has returned its credit by now
        check_value("credits", 32'(credits), 32'(hist_pkg::FIFO_DEPTH));
    endtask

    // host port has one cycle of read latency
    task automatic read_bin(input int a, output logic [31:0] v);
        step();
        rd_addr = 8'(a);
        step();
        v = rd_data;
    endtask

    task automatic check_all_bins();
        logic [31:0] v;
        for (int a = 0; a < hist_pkg::NUM_BINS; a++) begin
            read_bin(a, v);
            check_value($sformatf("rd_data bin %0d", a), v, model[a]);
        end
    endtask

    task automatic test_reset();
        check_value("done", 32'(done), 32'd0);
        check_value("credit", 32'(credit), 32'd0);
        check_value("busy", 32'(busy), 32'd0);
        check_value("total", total, 32'd0);
    endtask

    task automatic test_short();
        string s;
        logic [31:0] v;
        s = "abca";
        start_run();
        for (int i = 0; i < s.len(); i++) begin
            send_byte(s[i]);
        end
        send_byte(hist_pkg::EOF_CHAR);
        wait_done();
        check_value("total", total, 32'd5);
        read_bin(8'h61, v);
        check_value("rd_data bin a", v, 32'd2);
        read_bin(8'h62, v);
        check_value("rd_data bin b", v, 32'd1);
        read_bin(8'h63, v);
        check_value("rd_data bin c", v, 32'd1);
        read_bin(8'h1a, v);
        check_value("rd_data bin eof", v, 32'd1);
        // a few neighbours and extremes stay empty
        read_bin(8'h00, v);
        check_value("rd_data bin 0x00", v, 32'd0);
        read_bin(8'h64, v);
        check_value("rd_data bin d", v, 32'd0);
        read_bin(8'h1b, v);
        check_value("rd_data bin 0x1b", v, 32'd0);
        read_bin(8'hff, v);
        check_value("rd_data bin 0xff", v, 32'd0);
    endtask

    // full rate limited by credits only
    task automatic test_random();
        start_run();
        repeat (RAND_BYTES) send_byte(rand_byte());
        send_byte(hist_pkg::EOF_CHAR);
        wait_done();
        check_all_bins();
    endtask

    // bursts of 1 to 6 bytes with gaps of 0 to 9 idle cycles
    task automatic test_bursts();
        int sent;
        int burst;
        int gap;
        start_run();
        sent = 0;
        while (sent < BURST_BYTES) begin
            rng = xorshift32(rng);
            burst = 1 + int'(rng % 6);
            gap = int'((rng >> 8) % 10);
            for (int i = 0; i < burst && sent < BURST_BYTES; i++) begin
                send_byte(rand_byte());
                sent++;
            end
            repeat (gap) step();
        end
        send_byte(hist_pkg::EOF_CHAR);
        wait_done();
        check_all_bins();
    endtask

    // small alphabet where any leftover count from the last run would show up
    task automatic test_restart();
        start_run();
        repeat (RESTART_BYTES) send_byte(8'h78 + (rand_byte() % 8'd3));
        send_byte(hist_pkg::EOF_CHAR);
        wait_done();
        check_all_bins();
    endtask

    initial begin
        rst = 1'b1;
        start = 1'b0;
        byte_in = '0;
        rd_addr = '0;
        credits = hist_pkg::FIFO_DEPTH;
        errors = 0;
        rng = 32'h6612e9d8;
        model_total = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        step();
        test_reset();
        test_short();
        test_random();
        test_bursts();
        test_restart();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: verification/hist_assert.sv
`timescale 1ns/100ps

module hist_assert (
    input logic                  clk,
    input logic                  rst,
    input logic                  pop,
    input hist_pkg::byte_msg_t   head,
    input hist_pkg::ram_req_t    req,
    input logic                  busy,
    input logic                  done,
    input hist_pkg::ctrl_state_t state
);

    // busy cycles seen so far in the current access
    int busy_len;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_len <= 0;
        end else if (busy) begin
            busy_len <= busy_len + 1;
        end else begin
            busy_len <= 0;
        end
    end

    // a waiting byte stays put until it is popped
    // an overflowing push would overwrite it
    a_head_hold: assert property (@(posedge clk) disable iff (rst)
        (head.valid && !pop) |=> (head.valid && $stable(head.data)))
        else $error("byte at the buffer head lost or changed before its pop");

    // one access at a time
    a_req_idle: assert property (@(posedge clk) disable iff (rst) req.valid |-> !busy)
        else $error("memory request issued while busy");

    // never longer than the latency
    a_busy_max: assert property (@(posedge clk) disable iff (rst)
        busy |-> (busy_len < hist_pkg::SRAM_LAT))
        else $error("busy held longer than the memory latency");

    // and never shorter
    a_busy_len: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> (busy_len == hist_pkg::SRAM_LAT))
        else $error("busy dropped before the memory latency ran out");

    // a finished run leaves the memory and the buffer alone
    a_done_state: assert property (@(posedge clk) disable iff (rst)
        done |-> ((state == hist_pkg::DONE) && !busy && !req.valid && !pop))
        else $error("activity on memory or buffer while done is high");

endmodule

// every watched signal is visible inside the controller
bind histogram_ctrl hist_assert u_assert (
    .clk   (clk),
    .rst   (rst),
    .pop   (pop),
    .head  (head),
    .req   (req),
    .busy  (busy),
    .done  (done),
    .state (state)
);

// File: hdl/hist_top.sv
`timescale 1ns/100ps

module hist_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  hist_pkg::byte_msg_t         byte_in,
    output logic                        credit,
    output logic                        busy,
    output logic                        done,
    output logic [hist_pkg::BIN_W-1:0]  total,
    input  logic [hist_pkg::ADDR_W-1:0] rd_addr,
    output logic [hist_pkg::BIN_W-1:0]  rd_data
);

    // buffer head into the controller
    hist_pkg::byte_msg_t head;
    logic                pop;

    // controller to memory
    hist_pkg::ram_req_t         req;
    logic [hist_pkg::BIN_W-1:0] rdata;

    // credit-flow input buffer
    byte_credit_fifo u_fifo (
        .clk      (clk),
        .rst      (rst),
        .push_msg (byte_in),
        .pop      (pop),
        .head     (head),
        .credit   (credit)
    );

    histogram_ctrl u_ctrl (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .head  (head),
        .pop   (pop),
        .req   (req),
        .busy  (busy),
        .rdata (rdata),
        .total (total),
        .done  (done)
    );

    // busy also goes out so the host sees memory activity
    bin_ram u_ram (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .busy    (busy),
        .rdata   (rdata),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// File: hdl/histogram_ctrl.sv
`timescale 1ns/100ps

module histogram_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  hist_pkg::byte_msg_t        head,
    output logic                       pop,
    output hist_pkg::ram_req_t         req,
    input  logic                       busy,
    input  logic [hist_pkg::BIN_W-1:0] rdata,
    output logic [hist_pkg::BIN_W-1:0] total,
    output logic                       done
);

    hist_pkg::ctrl_state_t state;
    hist_pkg::ctrl_state_t next_state;

    // sweep address for the clear phase
    logic [hist_pkg::ADDR_W-1:0] clr_addr;
    // byte being counted addresses the write back
    logic [7:0] cur_byte;
    // set when the byte in flight is the end-of-file mark
    logic eof_flag;

    // one-cycle request strobes
    logic clr_issue;
    logic rd_issue;
    logic wr_issue;
    logic start_ok;

    // start honoured only when idle or finished
    assign start_ok = start && ((state == hist_pkg::IDLE) || (state == hist_pkg::DONE));

    // a zero write each time the memory goes idle
    assign clr_issue = (state == hist_pkg::CLEAR) && !busy;
    // read of the head byte's bin
    // the byte is popped in the same cycle
    assign rd_issue = (state == hist_pkg::FETCH) && head.valid && !busy;
    // count+1 back into the same bin
    // busy is already low here
    assign wr_issue = (state == hist_pkg::WRITE);

    assign pop = rd_issue;

    // memory request
    always_comb begin
        req.valid = clr_issue || rd_issue || wr_issue;
        req.write = clr_issue || wr_issue;
        if (clr_issue) begin
            req.addr = clr_addr;
        end else if (rd_issue) begin
            req.addr = head.data;
        end else begin
            req.addr = cur_byte;
        end
        // rdata holds the fetched count until the next access ends
        req.wdata = clr_issue ? '0 : (rdata + 1'b1);
    end

    // done only in the terminal state until the next start
    assign done = (state == hist_pkg::DONE);

    // next state
    always_comb begin
        next_state = state;
        case (state)
            hist_pkg::IDLE: begin
                if (start_ok) begin
                    next_state = hist_pkg::CLEAR;
                end
            end
            hist_pkg::CLEAR: begin
                // last zero write drains like a normal write
                if (clr_issue && (clr_addr == hist_pkg::LAST_BIN)) begin
                    next_state = hist_pkg::WAIT_WRITE;
                end
            end
            hist_pkg::FETCH: begin
                // stall here while the buffer is empty
                if (rd_issue) begin
                    next_state = hist_pkg::WAIT_READ;
                end
            end
            hist_pkg::WAIT_READ: begin
                if (!busy) begin
                    next_state = hist_pkg::WRITE;
                end
            end
            hist_pkg::WRITE: begin
                next_state = hist_pkg::WAIT_WRITE;
            end
            hist_pkg::WAIT_WRITE: begin
                if (!busy) begin
                    next_state = eof_flag ? hist_pkg::DONE : hist_pkg::FETCH;
                end
            end
            hist_pkg::DONE: begin
                if (start_ok) begin
                    next_state = hist_pkg::CLEAR;
                end
            end
            default: begin
                next_state = hist_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= hist_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // clear sweep address and eof mark restart with each run
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clr_addr <= '0;
            eof_flag <= 1'b0;
        end else begin
            if (start_ok) begin
                clr_addr <= '0;
                eof_flag <= 1'b0;
            end else begin
                if (clr_issue) begin
                    clr_addr <= clr_addr + 1'b1;
                end
                if (rd_issue) begin
                    eof_flag <= (head.data == hist_pkg::EOF_CHAR);
                end
            end
        end
    end

    // running byte count including the eof byte
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            total <= '0;
        end else if (start_ok) begin
            total <= '0;
        end else if (rd_issue) begin
            total <= total + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_issue) begin
            cur_byte <= head.data;
        end
    end

endmodule

// File: hdl/bin_ram.sv
`timescale 1ns/100ps

module bin_ram (
    input  logic                        clk,
    input  logic                        rst,
    input  hist_pkg::ram_req_t          req,
    output logic                        busy,
    output logic [hist_pkg::BIN_W-1:0]  rdata,
    input  logic [hist_pkg::ADDR_W-1:0] rd_addr,
    output logic [hist_pkg::BIN_W-1:0]  rd_data
);

    // one count word per byte value
    logic [hist_pkg::BIN_W-1:0] mem [hist_pkg::NUM_BINS];

    // request held for the length of the access
    logic [hist_pkg::ADDR_W-1:0] addr_q;
    logic [hist_pkg::BIN_W-1:0]  wdata_q;
    logic                        write_q;

    // remaining busy cycles after the current one
    logic [hist_pkg::LAT_CNT_W-1:0] lat_cnt;
    logic                           access_end;

    // array is touched on the edge that ends the last busy cycle
    assign access_end = busy && (lat_cnt == '0);

    always_ff @(posedge clk) begin
        if (req.valid) begin
            addr_q <= req.addr;
            wdata_q <= req.wdata;
            write_q <= req.write;
        end
    end

    // busy rises the cycle after the request and lasts SRAM_LAT cycles
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            lat_cnt <= '0;
        end else if (req.valid) begin
            busy <= 1'b1;
            lat_cnt <= hist_pkg::LAT_START;
        end else if (busy) begin
            if (lat_cnt == '0) begin
                busy <= 1'b0;
            end else begin
                lat_cnt <= lat_cnt - 1'b1;
            end
        end
    end

    // write commits or read word lands as busy drops
    always_ff @(posedge clk) begin
        if (access_end) begin
            if (write_q) begin
                mem[addr_q] <= wdata_q;
            end else begin
                rdata <= mem[addr_q];
            end
        end
    end

    // host side
    // independent registered read with one cycle of latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: hdl/byte_credit_fifo.sv
`timescale 1ns/100ps

module byte_credit_fifo (
    input  logic                clk,
    input  logic                rst,
    input  hist_pkg::byte_msg_t push_msg,
    input  logic                pop,
    output hist_pkg::byte_msg_t head,
    output logic                credit
);

    // byte storage
    logic [7:0] mem [hist_pkg::FIFO_DEPTH];

    logic [hist_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [hist_pkg::FIFO_PTR_W-1:0] rd_ptr;
    logic [hist_pkg::FIFO_CNT_W-1:0] count;

    logic do_push;
    logic do_pop;

    // sender holds credits, so a valid push always has room
    assign do_push = push_msg.valid;
    // pop on empty is ignored
    assign do_pop = pop && (count != '0);

    // head entry straight from storage
    assign head.valid = (count != '0);
    assign head.data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_msg.data;
        end
    end

    // pointers wrap at depth rather than at a power of two
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                if (wr_ptr == hist_pkg::FIFO_LAST_PTR) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr == hist_pkg::FIFO_LAST_PTR) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

    // occupancy
    // push and pop together leave it unchanged
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (do_push && !do_pop) begin
            count <= count + 1'b1;
        end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
        end
    end

    // credit pulse follows each removed byte by one clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credit <= 1'b0;
        end else begin
            credit <= do_pop;
        end
    end

endmodule

// File: hdl/hist_pkg.sv
package hist_pkg;

    // histogram geometry
    localparam int NUM_BINS = 256;
    localparam int BIN_W = 32;
    localparam int ADDR_W = 8;

    // input buffer depth equals the sender's starting credit
    localparam int FIFO_DEPTH = 4;

    // busy cycles per memory access
    localparam int SRAM_LAT = 2;

    // ascii substitute marks end of file
    localparam logic [7:0] EOF_CHAR = 8'h1a;

    // derived widths and terminal values
    localparam int FIFO_PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [FIFO_PTR_W-1:0] FIFO_LAST_PTR = FIFO_PTR_W'(FIFO_DEPTH - 1);
    localparam int LAT_CNT_W = $clog2(SRAM_LAT + 1);
    localparam logic [LAT_CNT_W-1:0] LAT_START = LAT_CNT_W'(SRAM_LAT - 1);
    localparam logic [ADDR_W-1:0] LAST_BIN = ADDR_W'(NUM_BINS - 1);

    // one byte on its way in
    // valid doubles as non-empty at the buffer head
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } byte_msg_t;

    // single-cycle request into the count memory
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [BIN_W-1:0]  wdata;
    } ram_req_t;

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        FETCH,
        WAIT_READ,
        WRITE,
        WAIT_WRITE,
        DONE
    } ctrl_state_t;

endpackage
